//--- Bender.yml
package:
  name: mem_queue

sources:
  - hdl/mq_pkg.sv
  - hdl/mq_fifo_if.sv
  - hdl/mq_fifo.sv
  - hdl/mq_load_path.sv
  - hdl/mq_store_path.sv
  - hdl/mem_queue.sv
  - target: simulation
    files:
      - sim/mbus_mem_model.sv
      - sim/mem_queue_tb.sv

//--- all.f
hdl/mq_pkg.sv
hdl/mq_fifo_if.sv
hdl/mq_fifo.sv
hdl/mq_load_path.sv
hdl/mq_store_path.sv
hdl/mem_queue.sv
sim/mbus_mem_model.sv
sim/mem_queue_tb.sv

//--- hdl/mem_queue.sv
`timescale 1ns/1ps
`default_nettype none

module mem_queue #(
    parameter int DEPTH_BITS = 4
) (
    input  logic             clk,
    input  logic             rst_n,

    output mq_pkg::mq_addr_t mbus_ar_addr,
    output logic             mbus_ar_valid,
    input  logic             mbus_ar_ready,
    input  mq_pkg::mq_data_t mbus_r_data,
    input  logic             mbus_r_valid,
    output logic             mbus_r_ready,

    output mq_pkg::mq_addr_t mbus_aw_addr,
    output logic             mbus_aw_valid,
    input  logic             mbus_aw_ready,
    output mq_pkg::mq_data_t mbus_w_data,
    output mq_pkg::mq_strb_t mbus_w_strb,
    output logic             mbus_w_valid,

    input  logic             mbus_b_resp,   // not used, write errors are not reported
    input  logic             mbus_b_valid,
    output logic             mbus_b_ready,

    input  logic             rvv_req,
    input  mq_pkg::mq_addr_t rvv_addr,
    input  logic             rvv_ready,
    output mq_pkg::mq_data_t rvv_rdata,
    output logic             rvv_rvalid,
    input  logic             rvv_wvalid,
    input  mq_pkg::mq_data_t rvv_wdata,
    input  mq_pkg::mq_strb_t rvv_be,

    output logic             rvv_done_ld,
    output logic             rvv_done_st
);

    mq_fifo_if #(.WIDTH(mq_pkg::addr_w), .DEPTH_BITS(DEPTH_BITS)) ar_if ();
    mq_fifo_if #(.WIDTH(mq_pkg::data_w), .DEPTH_BITS(DEPTH_BITS)) r_if ();
    mq_fifo_if #(.WIDTH(mq_pkg::addr_w), .DEPTH_BITS(DEPTH_BITS)) aw_if ();
    mq_fifo_if #(
        .WIDTH      (mq_pkg::data_w + mq_pkg::strb_w),
        .DEPTH_BITS (DEPTH_BITS)
    ) w_if ();

    mq_fifo #(.DATA_WIDTH(mq_pkg::addr_w), .DEPTH_BITS(DEPTH_BITS)) ar_q (
        .clk (clk), .rst_n (rst_n), .port (ar_if.fifo)
    );
    mq_fifo #(.DATA_WIDTH(mq_pkg::data_w), .DEPTH_BITS(DEPTH_BITS)) r_q (
        .clk (clk), .rst_n (rst_n), .port (r_if.fifo)
    );
    mq_fifo #(.DATA_WIDTH(mq_pkg::addr_w), .DEPTH_BITS(DEPTH_BITS)) aw_q (
        .clk (clk), .rst_n (rst_n), .port (aw_if.fifo)
    );
    mq_fifo #(
        .DATA_WIDTH (mq_pkg::data_w + mq_pkg::strb_w),
        .DEPTH_BITS (DEPTH_BITS)
    ) w_q (
        .clk (clk), .rst_n (rst_n), .port (w_if.fifo)
    );

    mq_load_path #(.DEPTH_BITS(DEPTH_BITS)) u_load (
        .clk           (clk),
        .rst_n         (rst_n),
        .rvv_req       (rvv_req),
        .rvv_addr      (rvv_addr),
        .rvv_ready     (rvv_ready),
        .rvv_rdata     (rvv_rdata),
        .rvv_rvalid    (rvv_rvalid),
        .rvv_done_ld   (rvv_done_ld),
        .mbus_ar_addr  (mbus_ar_addr),
        .mbus_ar_valid (mbus_ar_valid),
        .mbus_ar_ready (mbus_ar_ready),
        .mbus_r_data   (mbus_r_data),
        .mbus_r_valid  (mbus_r_valid),
        .mbus_r_ready  (mbus_r_ready),
        .ar_wr         (ar_if.writer),
        .ar_rd         (ar_if.reader),
        .r_wr          (r_if.writer),
        .r_rd          (r_if.reader)
    );

    mq_store_path #(.DEPTH_BITS(DEPTH_BITS)) u_store (
        .clk           (clk),
        .rst_n         (rst_n),
        .rvv_wvalid    (rvv_wvalid),
        .rvv_addr      (rvv_addr),   // shared with the load side
        .rvv_wdata     (rvv_wdata),
        .rvv_be        (rvv_be),
        .rvv_done_st   (rvv_done_st),
        .mbus_aw_addr  (mbus_aw_addr),
        .mbus_aw_valid (mbus_aw_valid),
        .mbus_aw_ready (mbus_aw_ready),
        .mbus_w_data   (mbus_w_data),
        .mbus_w_strb   (mbus_w_strb),
        .mbus_w_valid  (mbus_w_valid),
        .mbus_b_valid  (mbus_b_valid),
        .mbus_b_ready  (mbus_b_ready),
        .aw_wr         (aw_if.writer),
        .aw_rd         (aw_if.reader),
        .w_wr          (w_if.writer),
        .w_rd          (w_if.reader)
    );

endmodule

`default_nettype wire

//--- hdl/mq_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module mq_fifo #(
    parameter int DATA_WIDTH = 32,
    parameter int DEPTH_BITS = 4
) (
    input  logic    clk,
    input  logic    rst_n,
    mq_fifo_if.fifo port
);

    localparam int depth = 1 << DEPTH_BITS;

    logic [DATA_WIDTH-1:0] mem [depth];
    logic [DEPTH_BITS-1:0] wr_ptr;
    logic [DEPTH_BITS-1:0] rd_ptr;
    logic [DEPTH_BITS:0]   count;
    logic                  do_push;
    logic                  do_pop;

    // requests against a full or empty buffer fall on the floor
    assign do_push = port.push & ~port.full;
    assign do_pop  = port.pop & ~port.empty;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= port.push_data;
    end

    assign port.pop_data = mem[rd_ptr];  // fall-through read
    assign port.empty    = (count == '0);
    assign port.full     = (count == depth[DEPTH_BITS:0]);
    assign port.level    = count;

endmodule

`default_nettype wire

//--- hdl/mq_fifo_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mq_fifo_if #(
    parameter int WIDTH      = 32,
    parameter int DEPTH_BITS = 4
);

    logic                  push;
    logic [WIDTH-1:0]      push_data;
    logic                  pop;
    logic [WIDTH-1:0]      pop_data;  // head word, valid while not empty
    logic                  empty;
    logic                  full;
    logic [DEPTH_BITS:0]   level;     // 0 .. 2**DEPTH_BITS

    modport writer (output push, output push_data, input full);
    modport reader (output pop, input pop_data, input empty, input level);
    modport fifo (
        input  push, input  push_data, input  pop,
        output pop_data, output empty, output full, output level
    );

endinterface

`default_nettype wire

//--- hdl/mq_load_path.sv
`timescale 1ns/1ps
`default_nettype none

module mq_load_path #(
    parameter int DEPTH_BITS = 4
) (
    input  logic             clk,
    input  logic             rst_n,

    input  logic             rvv_req,
    input  mq_pkg::mq_addr_t rvv_addr,
    input  logic             rvv_ready,
    output mq_pkg::mq_data_t rvv_rdata,
    output logic             rvv_rvalid,
    output logic             rvv_done_ld,

    output mq_pkg::mq_addr_t mbus_ar_addr,
    output logic             mbus_ar_valid,
    input  logic             mbus_ar_ready,
    input  mq_pkg::mq_data_t mbus_r_data,
    input  logic             mbus_r_valid,
    output logic             mbus_r_ready,

    mq_fifo_if.writer        ar_wr,
    mq_fifo_if.reader        ar_rd,
    mq_fifo_if.writer        r_wr,
    mq_fifo_if.reader        r_rd
);

    localparam logic [DEPTH_BITS:0] len_one = {{DEPTH_BITS{1'b0}}, 1'b1};

    mq_pkg::load_state_t state;
    logic [DEPTH_BITS:0] burst_len;  // counts up while collecting, down while draining
    logic                outstanding;
    logic                ar_fire;
    logic                r_fire;
    logic                drain_go;

    // address side; requests outside idle/collect belong to no burst
    assign ar_wr.push      = rvv_req & (state == mq_pkg::idle || state == mq_pkg::collect);
    assign ar_wr.push_data = rvv_addr;

    // one read on the bus at a time
    assign mbus_ar_valid = ~ar_rd.empty & ~outstanding;
    assign mbus_ar_addr  = ar_rd.pop_data;
    assign mbus_r_ready  = outstanding;
    assign ar_fire       = mbus_ar_valid & mbus_ar_ready;
    assign r_fire        = mbus_r_valid & mbus_r_ready;
    assign ar_rd.pop     = ar_fire;

    assign r_wr.push      = r_fire;
    assign r_wr.push_data = mbus_r_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            outstanding <= 1'b0;
        else if (ar_fire)
            outstanding <= 1'b1;
        else if (r_fire)
            outstanding <= 1'b0;
    end

    // whole burst back and vector side willing
    assign drain_go = (state == mq_pkg::wait_data) & (r_rd.level == burst_len) & rvv_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= mq_pkg::idle;
            burst_len <= '0;
        end else begin
            case (state)
                mq_pkg::idle: begin
                    if (rvv_req) begin
                        state     <= mq_pkg::collect;
                        burst_len <= len_one;
                    end
                end
                mq_pkg::collect: begin
                    if (rvv_req)
                        burst_len <= burst_len + 1'b1;
                    else
                        state <= mq_pkg::wait_data;  // burst closed
                end
                mq_pkg::wait_data: begin
                    if (drain_go)
                        state <= mq_pkg::drain;
                end
                mq_pkg::drain: begin
                    burst_len <= burst_len - 1'b1;
                    if (burst_len == len_one)
                        state <= mq_pkg::idle;
                end
                default: state <= mq_pkg::idle;
            endcase
        end
    end

    // one word per cycle, rvv_ready no longer consulted
    assign rvv_rvalid  = (state == mq_pkg::drain);
    assign r_rd.pop    = rvv_rvalid;
    assign rvv_rdata   = r_rd.pop_data;
    assign rvv_done_ld = rvv_rvalid & (burst_len == len_one);

endmodule

`default_nettype wire

//--- hdl/mq_pkg.sv
`default_nettype none

package mq_pkg;

    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int strb_w = data_w / 8;

    typedef logic [addr_w-1:0] mq_addr_t;
    typedef logic [data_w-1:0] mq_data_t;
    typedef logic [strb_w-1:0] mq_strb_t;  // one enable per byte lane

    // load path sequencing, one burst in flight
    typedef enum logic [1:0] {
        idle,
        collect,
        wait_data,
        drain
    } load_state_t;

endpackage

`default_nettype wire

//--- hdl/mq_store_path.sv
`timescale 1ns/1ps
`default_nettype none

module mq_store_path #(
    parameter int DEPTH_BITS = 4
) (
    input  logic             clk,
    input  logic             rst_n,

    input  logic             rvv_wvalid,
    input  mq_pkg::mq_addr_t rvv_addr,
    input  mq_pkg::mq_data_t rvv_wdata,
    input  mq_pkg::mq_strb_t rvv_be,
    output logic             rvv_done_st,

    output mq_pkg::mq_addr_t mbus_aw_addr,
    output logic             mbus_aw_valid,
    input  logic             mbus_aw_ready,
    output mq_pkg::mq_data_t mbus_w_data,
    output mq_pkg::mq_strb_t mbus_w_strb,
    output logic             mbus_w_valid,
    input  logic             mbus_b_valid,
    output logic             mbus_b_ready,

    mq_fifo_if.writer        aw_wr,
    mq_fifo_if.reader        aw_rd,
    mq_fifo_if.writer        w_wr,
    mq_fifo_if.reader        w_rd
);

    logic [DEPTH_BITS:0] issued_cnt;
    logic [DEPTH_BITS:0] acked_cnt;
    logic                wr_valid;
    logic                issue;
    logic                ack;

    // both queues are pushed together so they never disagree on depth
    assign aw_wr.push      = rvv_wvalid;
    assign aw_wr.push_data = rvv_addr;
    assign w_wr.push       = rvv_wvalid;
    assign w_wr.push_data  = {rvv_be, rvv_wdata};  // strobe rides above the data

    assign wr_valid      = ~aw_rd.empty & ~w_rd.empty;
    assign mbus_aw_valid = wr_valid;
    assign mbus_w_valid  = wr_valid;
    assign mbus_aw_addr  = aw_rd.pop_data;
    assign {mbus_w_strb, mbus_w_data} = w_rd.pop_data;

    // aw_ready alone completes the write beat
    assign issue     = wr_valid & mbus_aw_ready;
    assign aw_rd.pop = issue;
    assign w_rd.pop  = issue;

    assign mbus_b_ready = (issued_cnt != '0);
    assign ack          = mbus_b_valid & mbus_b_ready;

    assign rvv_done_st = (issued_cnt == acked_cnt) & (issued_cnt != '0)
                         & aw_rd.empty & w_rd.empty;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            issued_cnt <= '0;
            acked_cnt  <= '0;
        end else if (rvv_done_st) begin
            issued_cnt <= '0;  // batch complete, start over
            acked_cnt  <= '0;
        end else begin
            if (issue)
                issued_cnt <= issued_cnt + 1'b1;
            if (ack)
                acked_cnt <= acked_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- sim/mbus_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module mbus_mem_model (
    input  logic             clk,
    input  logic             rst_n,
    input  mq_pkg::mq_addr_t ar_addr,
    input  logic             ar_valid,
    output logic             ar_ready,
    output mq_pkg::mq_data_t r_data,
    output logic             r_valid,
    input  logic             r_ready,
    input  mq_pkg::mq_addr_t aw_addr,
    input  logic             aw_valid,
    output logic             aw_ready,
    input  mq_pkg::mq_data_t w_data,
    input  mq_pkg::mq_strb_t w_strb,
    output logic             b_valid,
    input  logic             b_ready,
    output logic             b_resp
);

    integer           seed = 32'h5527c8ed;
    mq_pkg::mq_data_t mem [mq_pkg::mq_addr_t];  // sparse, filled on write
    mq_pkg::mq_addr_t r_addr;
    logic             r_busy;
    integer           r_wait;
    integer           b_pend;
    integer           b_wait;

    function automatic mq_pkg::mq_data_t read_word(input mq_pkg::mq_addr_t a);
        if (mem.exists(a))
            return mem[a];
        return a ^ 32'hdeadbeef;  // never written
    endfunction

    always @(posedge clk or negedge rst_n) begin
        logic [31:0]      rnd;
        mq_pkg::mq_data_t old;
        if (!rst_n) begin
            ar_ready <= 1'b0;
            aw_ready <= 1'b0;
            r_valid  <= 1'b0;
            r_data   <= '0;
            b_valid  <= 1'b0;
            b_resp   <= 1'b0;
            r_busy   = 1'b0;
            r_wait   = 0;
            b_pend   = 0;
            b_wait   = 0;
        end else begin
            rnd = $random(seed);
            ar_ready <= rnd[0];
            aw_ready <= rnd[1];
            if (ar_valid && ar_ready) begin
                r_addr = ar_addr;
                r_busy = 1'b1;
                r_wait = rnd[5:4];  // 0..3 cycles before data
            end else if (r_valid && r_ready) begin
                r_valid <= 1'b0;
            end else if (r_busy && !r_valid) begin
                if (r_wait == 0) begin
                    r_valid <= 1'b1;
                    r_data  <= read_word(r_addr);
                    r_busy  = 1'b0;
                end else begin
                    r_wait = r_wait - 1;
                end
            end
            if (aw_valid && aw_ready) begin
                old = read_word(aw_addr);
                for (int i = 0; i < mq_pkg::strb_w; i++)
                    if (w_strb[i])
                        old[8*i +: 8] = w_data[8*i +: 8];
                mem[aw_addr] = old;
                b_pend = b_pend + 1;
            end
            if (b_valid && b_ready) begin
                b_valid <= 1'b0;
                b_pend = b_pend - 1;
                b_wait = rnd[9:8];
            end else if (!b_valid && b_pend > 0) begin
                if (b_wait == 0)
                    b_valid <= 1'b1;
                else
                    b_wait = b_wait - 1;
            end
        end
    end

endmodule

`default_nettype wire

//--- sim/mem_queue_cases.txt
# op (store, load, load_hold)  base address (hex)  beats (dec)  data seed (hex)
# store data is seed+k, strobe alternates f and seed[3:0]
store     00001000  4   11223340
load      00001000  4   00000000
load      00002000  8   00000000
store     00002000  8   a5a5a5a3
load      00002000  8   00000000
load_hold 00001000  4   00000000
store     00003000  16  0badf00c
load      00003000  16  00000000
load      00002ff8  6   00000000
store     00000100  1   12345678
load      00000100  1   00000000
load_hold 00003000  16  00000000
store     00001008  3   cafe0001
load      00001000  6   00000000
load      00004000  2   00000000
load_hold 00000100  1   00000000
store     00005000  5   00000009
load      00005000  5   00000000

//--- sim/mem_queue_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mem_queue_tb;

    localparam int depth_bits = 4;
    localparam int wait_limit = 400;  // cycles per wait loop

    logic             clk;
    logic             rst_n;
    mq_pkg::mq_addr_t mbus_ar_addr, mbus_aw_addr, rvv_addr;
    logic             mbus_ar_valid, mbus_ar_ready, mbus_r_valid, mbus_r_ready;
    mq_pkg::mq_data_t mbus_r_data, mbus_w_data, rvv_rdata, rvv_wdata;
    logic             mbus_aw_valid, mbus_aw_ready, mbus_w_valid;
    mq_pkg::mq_strb_t mbus_w_strb, rvv_be;
    logic             mbus_b_resp, mbus_b_valid, mbus_b_ready;
    logic             rvv_req, rvv_ready, rvv_rvalid, rvv_wvalid;
    logic             rvv_done_ld, rvv_done_st;

    integer err_cnt = 0;
    integer to_cnt = 0;
    integer ar_cnt = 0;
    integer r_cnt = 0;
    integer b_cnt = 0;
    integer b_at_done = 0;
    integer st_done_cnt = 0;
    integer ld_done_cnt = 0;
    integer rd_out = 0;
    integer run = 0;
    integer ld_len = 0;
    mq_pkg::mq_addr_t exp_aw[$];
    mq_pkg::mq_data_t exp_w[$];
    mq_pkg::mq_strb_t exp_strb[$];
    mq_pkg::mq_addr_t exp_ar[$];
    mq_pkg::mq_data_t exp_rd[$];
    mq_pkg::mq_data_t mirror [mq_pkg::mq_addr_t];

    mem_queue #(.DEPTH_BITS(depth_bits)) UUT (.*);

    mbus_mem_model mem_model (
        .clk (clk), .rst_n (rst_n),
        .ar_addr (mbus_ar_addr), .ar_valid (mbus_ar_valid), .ar_ready (mbus_ar_ready),
        .r_data (mbus_r_data), .r_valid (mbus_r_valid), .r_ready (mbus_r_ready),
        .aw_addr (mbus_aw_addr), .aw_valid (mbus_aw_valid), .aw_ready (mbus_aw_ready),
        .w_data (mbus_w_data), .w_strb (mbus_w_strb),
        .b_valid (mbus_b_valid), .b_ready (mbus_b_ready), .b_resp (mbus_b_resp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic mq_pkg::mq_data_t mirror_word(input mq_pkg::mq_addr_t a);
        if (mirror.exists(a))
            return mirror[a];
        return a ^ 32'hdeadbeef;
    endfunction

    task automatic fail_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        $display("CHECK FAILED %s expected %h got %h at %0t", name, exp, act, $time);
        err_cnt++;
    endtask

    // bus side monitors
    always @(posedge clk) begin
        if (rst_n && mbus_aw_valid && mbus_aw_ready) begin
            if (exp_aw.size() == 0) begin
                $display("unexpected write on the bus at %0t", $time);
                err_cnt++;
            end else begin
                if (mbus_aw_addr !== exp_aw[0])
                    fail_value("mbus_aw_addr", exp_aw[0], mbus_aw_addr);
                if (mbus_w_data !== exp_w[0])
                    fail_value("mbus_w_data", exp_w[0], mbus_w_data);
                if (mbus_w_strb !== exp_strb[0])
                    fail_value("mbus_w_strb", exp_strb[0], mbus_w_strb);
                void'(exp_aw.pop_front());
                void'(exp_w.pop_front());
                void'(exp_strb.pop_front());
            end
            if (!mbus_w_valid)
                fail_value("mbus_w_valid", 1, mbus_w_valid);
        end
        if (rst_n && rvv_done_st) begin
            st_done_cnt++;
            b_at_done = b_cnt;  // responses taken on earlier edges
        end
        if (rst_n && mbus_b_valid && mbus_b_ready)
            b_cnt++;
        if (rst_n && mbus_ar_valid && mbus_ar_ready) begin
            if (rd_out != 0)
                fail_value("reads outstanding", 0, rd_out);
            rd_out++;
            ar_cnt++;
            if (exp_ar.size() == 0) begin
                $display("unexpected read on the bus at %0t", $time);
                err_cnt++;
            end else begin
                if (mbus_ar_addr !== exp_ar[0])
                    fail_value("mbus_ar_addr", exp_ar[0], mbus_ar_addr);
                void'(exp_ar.pop_front());
            end
        end
        if (rst_n && mbus_r_valid && mbus_r_ready) begin
            rd_out--;
            r_cnt++;
        end
    end

    // vector return monitor checks that words come back to back
    always @(posedge clk) begin
        if (rst_n && rvv_rvalid) begin
            if (exp_rd.size() == 0) begin
                $display("load word returned with none expected at %0t", $time);
                err_cnt++;
            end else if (rvv_rdata !== exp_rd[0])
                fail_value("rvv_rdata", exp_rd[0], rvv_rdata);
            if (exp_rd.size() != 0)
                void'(exp_rd.pop_front());
            if (rvv_done_ld !== (run + 1 == ld_len))
                fail_value("rvv_done_ld", run + 1 == ld_len, rvv_done_ld);
            run++;
        end else begin
            if (run != 0 && run != ld_len)
                fail_value("load words in a row", ld_len, run);
            run = 0;
            if (rst_n && rvv_done_ld)
                fail_value("rvv_done_ld", 0, rvv_done_ld);
        end
        if (rst_n && rvv_done_ld)
            ld_done_cnt++;
    end

    task automatic run_store(input mq_pkg::mq_addr_t base, input integer n,
                             input mq_pkg::mq_data_t seed);
        integer           done0;
        integer           b0;
        integer           cyc;
        mq_pkg::mq_data_t d;
        mq_pkg::mq_strb_t s;
        mq_pkg::mq_data_t m;
        done0 = st_done_cnt;
        b0 = b_cnt;
        for (int k = 0; k < n; k++) begin
            d = seed + k;
            s = (k % 2 == 0) ? 4'hf : seed[3:0];
            m = mirror_word(base + 4 * k);
            for (int i = 0; i < 4; i++)
                if (s[i])
                    m[8*i +: 8] = d[8*i +: 8];
            mirror[base + 4 * k] = m;
            exp_aw.push_back(base + 4 * k);
            exp_w.push_back(d);
            exp_strb.push_back(s);
            @(posedge clk);
            #1;
            rvv_wvalid = 1'b1;
            rvv_addr = base + 4 * k;
            rvv_wdata = d;
            rvv_be = s;
        end
        @(posedge clk);
        #1;
        rvv_wvalid = 1'b0;
        cyc = 0;
        while (st_done_cnt == done0 && cyc < wait_limit) begin
            @(posedge clk);
            #2;
            cyc++;
        end
        if (st_done_cnt == done0) begin
            $display("timeout waiting for store done at %h", base);
            to_cnt++;
        end else if (b_at_done - b0 != n)
            fail_value("b responses before store done", n, b_at_done - b0);
        repeat (6) @(posedge clk);
        #2;
        if (st_done_cnt - done0 != 1)
            fail_value("rvv_done_st pulses", 1, st_done_cnt - done0);
        if (exp_aw.size() != 0)
            fail_value("writes left unissued", 0, exp_aw.size());
    endtask

    task automatic run_load(input mq_pkg::mq_addr_t base, input integer n, input bit hold);
        integer r0;
        integer done0;
        integer cyc;
        r0 = r_cnt;
        done0 = ld_done_cnt;
        ld_len = n;
        for (int k = 0; k < n; k++) begin
            exp_ar.push_back(base + 4 * k);
            exp_rd.push_back(mirror_word(base + 4 * k));
        end
        for (int k = 0; k < n; k++) begin
            @(posedge clk);
            #1;
            rvv_ready = !hold;
            rvv_req = 1'b1;
            rvv_addr = base + 4 * k;
        end
        @(posedge clk);
        #1;
        rvv_req = 1'b0;
        if (hold) begin
            cyc = 0;
            while (r_cnt - r0 < n && cyc < wait_limit) begin
                @(posedge clk);
                #2;
                cyc++;
            end
            if (r_cnt - r0 < n) begin
                $display("timeout waiting for read data at %h", base);
                to_cnt++;
            end
            repeat (5) begin
                @(posedge clk);
                #1;
                if (rvv_rvalid)
                    fail_value("rvv_rvalid while held", 0, rvv_rvalid);
            end
            rvv_ready = 1'b1;
        end
        cyc = 0;
        while (ld_done_cnt == done0 && cyc < wait_limit) begin
            @(posedge clk);
            #2;
            cyc++;
        end
        if (ld_done_cnt == done0) begin
            $display("timeout waiting for load done at %h", base);
            to_cnt++;
        end
        repeat (3) @(posedge clk);
        #2;
        if (exp_rd.size() != 0)
            fail_value("load words missing", 0, exp_rd.size());
        if (exp_ar.size() != 0)
            fail_value("reads left unissued", 0, exp_ar.size());
        if (ld_done_cnt - done0 != 1)
            fail_value("rvv_done_ld pulses", 1, ld_done_cnt - done0);
    endtask

    initial begin
        integer           fd;
        integer           cnt;
        reg [8*16-1:0]    op;
        reg [8*200-1:0]   rest;
        mq_pkg::mq_addr_t base;
        integer           n;
        mq_pkg::mq_data_t seed;
        rst_n = 1'b0;
        rvv_req = 1'b0;
        rvv_addr = '0;
        rvv_ready = 1'b1;
        rvv_wvalid = 1'b0;
        rvv_wdata = '0;
        rvv_be = '0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (4) begin
            if (mbus_ar_valid || mbus_r_ready || mbus_aw_valid || mbus_w_valid
                || rvv_rvalid || rvv_done_ld || rvv_done_st)
                fail_value("control outputs after reset", 0,
                           {mbus_ar_valid, mbus_r_ready, mbus_aw_valid, mbus_w_valid,
                            rvv_rvalid, rvv_done_ld, rvv_done_st});
            @(posedge clk);
            #1;
        end
        fd = $fopen("sim/mem_queue_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open the cases file");
            err_cnt++;
        end else begin
            while ($fscanf(fd, "%s", op) == 1) begin
                if (op == "#") begin
                    cnt = $fgets(rest, fd);  // comment line
                end else begin
                    cnt = $fscanf(fd, "%h %d %h", base, n, seed);
                    if (cnt != 3) begin
                        $display("malformed line in the cases file");
                        err_cnt++;
                    end else if (op == "store")
                        run_store(base, n, seed);
                    else if (op == "load")
                        run_load(base, n, 1'b0);
                    else if (op == "load_hold")
                        run_load(base, n, 1'b1);
                    else begin
                        $display("unknown operation in the cases file");
                        err_cnt++;
                    end
                end
            end
            $fclose(fd);
        end
        $display("errors %0d, timeouts %0d, reads %0d, write responses %0d",
                 err_cnt, to_cnt, ar_cnt, b_cnt);
        if (err_cnt == 0 && to_cnt == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire
